// ==== all.f ====
design/cen_pkg.sv
design/cen_lane_if.sv
design/cen_base_div.sv
design/cen_frac.sv
design/cen_rate_meter.sv
design/cen_top.sv
tests/cen_checker.sv
tests/tb_clock.sv
tests/cen_tb.sv

// ==== design/cen_base_div.sv ====
// Binary divider: 12/6/3/1.5 MHz enables from 48 MHz, plus lane advance and restart
`default_nettype none

module cen_base_div (
    input  logic       clk,       // 48 MHz
    input  logic       reset,
    input  logic       resync,    // Restart all counters in phase
    output logic       cen12,
    output logic       cen12b,
    output logic       cen6,
    output logic       cen6b,
    output logic       cen3,
    output logic       cen3b,
    output logic       cen3q,     // Quarter period ahead of cen3
    output logic       cen3qb,
    output logic       cen1p5,
    output logic       cen1p5b,
    cen_lane_if.src    lanes [cen_pkg::NUM_LANES]
);

    import cen_pkg::*;

    div_t cnt;        // Free-running divider
    logic arm;        // Set through reset, fires the first restart
    logic clear;      // Realign everything at this edge
    logic restart;    // One cycle, counter sits at 0

    assign clear = arm | resync;

    ////////////////////////////////
    // Counter and restart
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt     <= '0;
            arm     <= 1'b1;
            restart <= 1'b0;
        end else begin
            arm     <= 1'b0;
            restart <= clear;                          // Lands in the cycle after
            cnt     <= clear ? div_t'(0) : cnt + div_t'(1);
        end
    end

    ////////////////////////////////
    // Registered compares
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            {cen12, cen12b, cen6, cen6b, cen3} <= '0;
            {cen3b, cen3q, cen3qb, cen1p5, cen1p5b} <= '0;
        end else begin
            cen12   <= cnt[1:0] == 2'd0;
            cen12b  <= cnt[1:0] == 2'd2;    // 180 degrees
            cen6    <= cnt[2:0] == 3'd0;
            cen6b   <= cnt[2:0] == 3'd4;
            cen3    <= cnt[3:0] == 4'd0;
            cen3b   <= cnt[3:0] == 4'd8;
            cen3q   <= cnt[3:0] == 4'd12;   // Quarter phases
            cen3qb  <= cnt[3:0] == 4'd4;
            cen1p5  <= cnt == 5'd0;
            cen1p5b <= cnt == 5'd16;
        end
    end

    ////////////////////////////////
    // Lane drive
    ////////////////////////////////

    // Advance held off while realigning, slow lanes step on odd counts only
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign lanes[i].restart = restart;
        assign lanes[i].advance = ~(restart | clear) & (~LANE_SLOW[i] | cnt[0]);
    end

endmodule

`default_nettype wire

// ==== design/cen_frac.sv ====
// Fractional lane: phase accumulator enable with overflow recovery and half-rate companion
`default_nettype none

module cen_frac #(
    parameter int LANE = 0           // Index into the package rate tables
) (
    input  logic       clk,
    input  logic       reset,
    cen_lane_if.lane   bus
);

    import cen_pkg::*;

    localparam phase_t STEP   = LANE_STEP[LANE];
    localparam phase_t LIM    = LANE_LIM[LANE];
    localparam phase_t ABSMAX = STEP + LIM;   // Never reached in normal running

    phase_t acc;          // Phase accumulator
    phase_t next_phase;   // acc + STEP
    phase_t wrap_phase;   // Remainder after a wrap
    logic   alt;          // Alternation for cen_half

    assign next_phase = acc + STEP;
    assign wrap_phase = next_phase - LIM;

    ////////////////////////////////
    // Accumulator
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || bus.restart) begin
            acc          <= '0;
            alt          <= 1'b0;
            bus.cen      <= 1'b0;
            bus.cen_half <= 1'b0;
        end else if (acc >= ABSMAX) begin
            // Corrupted phase, start over and let one pulse out
            acc          <= '0;
            alt          <= 1'b0;
            bus.cen      <= 1'b1;
            bus.cen_half <= 1'b0;
        end else if (bus.advance) begin
            if (next_phase >= LIM) begin
                acc          <= wrap_phase;   // Keep the fraction
                bus.cen      <= 1'b1;
                bus.cen_half <= alt;          // Odd pulses only
                alt          <= ~alt;
            end else begin
                acc          <= next_phase;
                bus.cen      <= 1'b0;
                bus.cen_half <= 1'b0;
            end
        end else begin
            // Slow lane idle cycle
            bus.cen      <= 1'b0;
            bus.cen_half <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/cen_lane_if.sv ====
// Fractional lane bus: advance and restart from the divider, strobes out to the meter
`default_nettype none

interface cen_lane_if;

    logic advance;   // Accumulator may step this cycle
    logic restart;   // Single-cycle realignment pulse
    logic cen;       // Lane enable strobe
    logic cen_half;  // Every second cen

    // Divider side
    modport src (
        output advance,
        output restart
    );

    // Fractional lane itself
    modport lane (
        input  advance,
        input  restart,
        output cen,
        output cen_half
    );

    // Rate meter only needs the strobe and the restart
    modport sink (
        input  cen,
        input  restart
    );

endinterface

`default_nettype wire

// ==== design/cen_pkg.sv ====
// Clock-enable package: lane count, fractional lane rate tables, meter window, width types
`default_nettype none

package cen_pkg;

    ////////////////////////////////
    // Sizes
    ////////////////////////////////

    localparam int NUM_LANES    = 4;     // Fractional lanes
    localparam int METER_WINDOW = 4096;  // Meter window in clk cycles

    typedef logic [15:0] phase_t;        // Accumulator word
    typedef logic [15:0] count_t;        // Pulses per window
    typedef logic [4:0]  div_t;          // Binary divider, 48 MHz down to 1.5 MHz
    typedef logic [$clog2(METER_WINDOW)-1:0] window_t;

    ////////////////////////////////
    // Lane rate tables
    ////////////////////////////////

    // Rate = advance rate * STEP / LIM
    //   lane 0: 48 MHz * 3758 / 50393 = 3.579545 MHz (NTSC colour burst)
    //   lane 1: 48 MHz * 1 / 125      = 384 kHz
    //   lane 2: 48 MHz * 5 / 24       = 10 MHz
    //   lane 3: 24 MHz * 8 / 125      = 1.536 MHz
    localparam phase_t LANE_STEP [NUM_LANES] = '{
        16'd3758,
        16'd1,
        16'd5,
        16'd8
    };

    localparam phase_t LANE_LIM [NUM_LANES] = '{
        16'd50393,
        16'd125,
        16'd24,
        16'd125
    };

    // Lane advances only on odd divider counts (24 MHz)
    localparam bit LANE_SLOW [NUM_LANES] = '{
        1'b0,
        1'b0,
        1'b0,
        1'b1
    };

endpackage

`default_nettype wire

// ==== design/cen_rate_meter.sv ====
// Rate meter: counts each lane's enable pulses over a fixed window for a debug display
`default_nettype none

module cen_rate_meter (
    input  logic       clk,
    input  logic       reset,
    cen_lane_if.sink   lanes [cen_pkg::NUM_LANES],
    output cen_pkg::count_t [cen_pkg::NUM_LANES-1:0] meter_count,
    output logic       meter_valid    // Counts updated
);

    import cen_pkg::*;

    window_t win;       // Cycle in the window
    logic    restart;   // Shared by all lanes
    logic    last;      // Final window cycle

    assign restart = lanes[0].restart;
    assign last    = win == window_t'(METER_WINDOW - 1);

    ////////////////////////////////
    // Window
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || restart) begin
            win         <= '0;
            meter_valid <= 1'b0;
        end else begin
            win         <= win + window_t'(1);   // Wraps at the window length
            meter_valid <= last;
        end
    end

    ////////////////////////////////
    // Per-lane tallies
    ////////////////////////////////

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        count_t tally;   // Running count this window
        count_t held;    // Last published count

        always_ff @(posedge clk) begin
            if (reset || restart) begin
                tally <= '0;
                held  <= '0;
            end else if (last) begin
                held  <= tally + count_t'(lanes[i].cen);   // Last-cycle pulse included
                tally <= '0;
            end else if (lanes[i].cen) begin
                tally <= tally + count_t'(1);
            end
        end

        assign meter_count[i] = held;
    end

endmodule

`default_nettype wire

// ==== design/cen_top.sv ====
// Clock-enable generator top: binary divider, fractional lanes and rate meter
`default_nettype none

module cen_top (
    input  logic       clk,        // 48 MHz
    input  logic       reset,
    input  logic       resync,
    // Binary enables
    output logic       cen12,
    output logic       cen12b,
    output logic       cen6,
    output logic       cen6b,
    output logic       cen3,
    output logic       cen3b,
    output logic       cen3q,
    output logic       cen3qb,
    output logic       cen1p5,
    output logic       cen1p5b,
    // Fractional lanes
    output logic [cen_pkg::NUM_LANES-1:0] lane_cen,
    output logic [cen_pkg::NUM_LANES-1:0] lane_cen_half,
    // Debug meter
    output cen_pkg::count_t [cen_pkg::NUM_LANES-1:0] meter_count,
    output logic       meter_valid
);

    import cen_pkg::*;

    cen_lane_if lane_bus [NUM_LANES] ();

    ////////////////////////////////
    // Divider
    ////////////////////////////////

    cen_base_div u_div (
        .clk     (clk),
        .reset   (reset),
        .resync  (resync),
        .cen12   (cen12),
        .cen12b  (cen12b),
        .cen6    (cen6),
        .cen6b   (cen6b),
        .cen3    (cen3),
        .cen3b   (cen3b),
        .cen3q   (cen3q),
        .cen3qb  (cen3qb),
        .cen1p5  (cen1p5),
        .cen1p5b (cen1p5b),
        .lanes   (lane_bus)
    );

    ////////////////////////////////
    // Lanes
    ////////////////////////////////

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        cen_frac #(.LANE(i)) u_frac (
            .clk   (clk),
            .reset (reset),
            .bus   (lane_bus[i])
        );

        assign lane_cen[i]      = lane_bus[i].cen;
        assign lane_cen_half[i] = lane_bus[i].cen_half;
    end

    cen_rate_meter u_meter (
        .clk         (clk),
        .reset       (reset),
        .lanes       (lane_bus),
        .meter_count (meter_count),
        .meter_valid (meter_valid)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the clock-enable testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module cen_tb -f all.f -o cen_sim

status=0
./obj_dir/cen_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "test failed" sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation FAILED"
    exit 1
fi
grep -q "test passed" sim.log
echo "Simulation PASSED"

// ==== tests/cen_checker.sv ====
// Bound assertions on the enable phases, lane companions and meter strobe
`default_nettype none

module cen_checker (
    input logic                           clk,
    input logic                           reset,
    input logic                           cen12,
    input logic                           cen12b,
    input logic [cen_pkg::NUM_LANES-1:0]  lane_cen,
    input logic [cen_pkg::NUM_LANES-1:0]  lane_cen_half,
    input logic                           meter_valid
);

    int fails = 0;   // Read back by the testbench at the end

    // 180 degree phases never overlap
    a_cen12_phase : assert property (@(posedge clk) disable iff (reset)
        !(cen12 && cen12b))
    else begin
        fails++;
        $error("cen12 and cen12b high in the same cycle");
    end

    // Half-rate pulse only on a lane pulse
    a_half_in_cen : assert property (@(posedge clk) disable iff (reset)
        (lane_cen_half & ~lane_cen) == '0)
    else begin
        fails++;
        $error("lane_cen_half high without lane_cen");
    end

    a_valid_single : assert property (@(posedge clk) disable iff (reset)
        meter_valid |=> !meter_valid)   // One-cycle strobe
    else begin
        fails++;
        $error("meter_valid high in two consecutive cycles");
    end

endmodule

bind cen_top cen_checker u_chk (
    .clk           (clk),
    .reset         (reset),
    .cen12         (cen12),
    .cen12b        (cen12b),
    .lane_cen      (lane_cen),
    .lane_cen_half (lane_cen_half),
    .meter_valid   (meter_valid)
);

`default_nettype wire

// ==== tests/cen_tb.sv ====
// Testbench for the clock-enable generator with cycle models of divider, lanes and meter
`default_nettype none

module cen_tb;

    import cen_pkg::*;

    localparam int TIMEOUT   = 7 * METER_WINDOW + 200;
    localparam int NUM_TESTS = 5;

    logic                   clk;
    logic                   reset;
    logic                   resync;
    logic [9:0]             bin_en;         // cen12 at bit 9 down to cen1p5b at bit 0
    logic [NUM_LANES-1:0]   lane_cen;
    logic [NUM_LANES-1:0]   lane_cen_half;
    count_t [NUM_LANES-1:0] meter_count;
    logic                   meter_valid;

    //////////////////////////////
    // Model state
    //////////////////////////////

    logic                   m_arm;          // Pending first restart
    logic                   m_restart;
    div_t                   m_cnt;
    logic [9:0]             m_en;
    phase_t                 m_acc [NUM_LANES];
    logic [NUM_LANES-1:0]   m_alt;
    logic [NUM_LANES-1:0]   m_cen;
    logic [NUM_LANES-1:0]   m_half;
    int                     m_win;          // Cycles into the window
    count_t                 m_tally [NUM_LANES];
    count_t [NUM_LANES-1:0] m_held;
    logic                   m_valid;

    logic after_resync;                     // Routes results to test 5
    int   valid_seen;
    int   pulses [NUM_LANES];
    int   halves;
    int   checks [NUM_TESTS];
    int   errs [NUM_TESTS];

    string bin_name [10] = '{"cen1p5b", "cen1p5", "cen3qb", "cen3q", "cen3b",
                             "cen3", "cen6b", "cen6", "cen12b", "cen12"};
    string test_name [NUM_TESTS] = '{"binary enables", "lane pulses",
                                     "half-rate companion", "meter counts", "resync"};

    tb_clock u_clock (.clk(clk));

    cen_top UUT (
        .clk           (clk),
        .reset         (reset),
        .resync        (resync),
        .cen12         (bin_en[9]),
        .cen12b        (bin_en[8]),
        .cen6          (bin_en[7]),
        .cen6b         (bin_en[6]),
        .cen3          (bin_en[5]),
        .cen3b         (bin_en[4]),
        .cen3q         (bin_en[3]),
        .cen3qb        (bin_en[2]),
        .cen1p5        (bin_en[1]),
        .cen1p5b       (bin_en[0]),
        .lane_cen      (lane_cen),
        .lane_cen_half (lane_cen_half),
        .meter_count   (meter_count),
        .meter_valid   (meter_valid)
    );

    //////////////////////////////
    // Reference functions
    //////////////////////////////

    // Enables due one cycle after the divider holds c
    function automatic logic [9:0] bin_ref(input div_t c);
        return {c[1:0] == 2'd0, c[1:0] == 2'd2, c[2:0] == 3'd0, c[2:0] == 3'd4,
                c[3:0] == 4'd0, c[3:0] == 4'd8, c[3:0] == 4'd12, c[3:0] == 4'd4,
                c == 5'd0, c == 5'd16};
    endfunction

    // One lane step returning {acc, alt, cen, cen_half}
    function automatic logic [18:0] lane_ref(input int lane, input phase_t acc,
                                             input logic alt, input logic adv);
        phase_t step;
        phase_t lim;
        phase_t nxt;
        step = LANE_STEP[lane];
        lim  = LANE_LIM[lane];
        nxt  = acc + step;
        if (acc >= step + lim)
            return {phase_t'(0), 1'b0, 1'b1, 1'b0};   // Recovery pulse
        if (!adv)
            return {acc, alt, 2'b00};
        if (nxt >= lim)
            return {phase_t'(nxt - lim), ~alt, 1'b1, alt};
        return {nxt, alt, 2'b00};
    endfunction

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_bit(input int t, input string what, input logic got, input logic exp);
        checks[t]++;
        if (got !== exp) begin
            errs[t]++;
            $display("[ERROR] %0t %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int t, input string what, input count_t got,
                               input count_t exp);
        checks[t]++;
        if (got !== exp) begin
            errs[t]++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input int t);
        $display("Test %0d %s: %0d checks, %0d errors", t + 1, test_name[t], checks[t], errs[t]);
    endtask

    //////////////////////////////
    // Compare then step the models
    //////////////////////////////

    always @(posedge clk) begin : compare
        logic                 clear;
        logic [NUM_LANES-1:0] adv;
        int                   bt;
        int                   lt;
        int                   ht;
        int                   mt;
        bt = after_resync ? 4 : 0;
        lt = after_resync ? 4 : 1;
        ht = after_resync ? 4 : 2;
        mt = after_resync ? 4 : 3;
        if (!reset) begin
            for (int i = 0; i < 10; i++)
                check_bit(bt, bin_name[i], bin_en[i], m_en[i]);
            for (int i = 0; i < NUM_LANES; i++) begin
                check_bit(lt, $sformatf("lane_cen[%0d]", i), lane_cen[i], m_cen[i]);
                check_bit(ht, $sformatf("lane_cen_half[%0d]", i), lane_cen_half[i], m_half[i]);
                if (lane_cen[i])
                    pulses[i]++;
                if (lane_cen_half[i])
                    halves++;
            end
            check_bit(mt, "meter_valid", meter_valid, m_valid);
            if (meter_valid)
                valid_seen++;
            if (m_valid) begin
                for (int i = 0; i < NUM_LANES; i++)
                    check_count(mt, $sformatf("meter_count[%0d]", i), meter_count[i], m_held[i]);
            end
        end

        if (reset) begin
            m_arm     = 1'b1;
            m_restart = 1'b0;
            m_cnt     = '0;
            m_en      = '0;
            m_alt     = '0;
            m_cen     = '0;
            m_half    = '0;
            m_win     = 0;
            m_held    = '0;
            m_valid   = 1'b0;
            for (int i = 0; i < NUM_LANES; i++) begin
                m_acc[i]   = '0;
                m_tally[i] = '0;
            end
        end else begin
            clear = m_arm | resync;
            for (int i = 0; i < NUM_LANES; i++)
                adv[i] = !(m_restart || clear) && (!LANE_SLOW[i] || m_cnt[0]);
            // Meter sees the lane pulses of this cycle
            if (m_restart) begin
                m_win   = 0;
                m_valid = 1'b0;
                m_held  = '0;
                for (int i = 0; i < NUM_LANES; i++)
                    m_tally[i] = '0;
            end else begin
                m_valid = m_win == METER_WINDOW - 1;
                for (int i = 0; i < NUM_LANES; i++) begin
                    if (m_valid) begin
                        m_held[i]  = m_tally[i] + count_t'(m_cen[i]);
                        m_tally[i] = '0;
                    end else begin
                        m_tally[i] = m_tally[i] + count_t'(m_cen[i]);
                    end
                end
                m_win = m_valid ? 0 : m_win + 1;
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                if (m_restart) begin
                    m_acc[i]  = '0;
                    m_alt[i]  = 1'b0;
                    m_cen[i]  = 1'b0;
                    m_half[i] = 1'b0;
                end else begin
                    {m_acc[i], m_alt[i], m_cen[i], m_half[i]} =
                        lane_ref(i, m_acc[i], m_alt[i], adv[i]);
                end
            end
            m_en      = clear ? '0 : bin_ref(m_cnt);
            m_cnt     = clear ? '0 : m_cnt + div_t'(1);
            m_restart = clear;
            m_arm     = 1'b0;
        end
    end

    //////////////////////////////
    // Stimulus and report
    //////////////////////////////

    initial begin : stimulus
        int unsigned gap;
        int          total_checks;
        int          total_errs;
        void'($urandom(61463));
        reset        = 1'b1;
        resync       = 1'b0;
        after_resync = 1'b0;
        total_checks = 0;
        total_errs   = 0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // Tests 1 to 4 run side by side over two windows
        while (valid_seen < 2)
            @(negedge clk);
        for (int i = 0; i < NUM_LANES; i++) begin
            if (pulses[i] == 0) begin
                $display("Lane %0d produced no pulses in two windows", i);
                errs[1]++;
            end
        end
        if (halves == 0) begin
            $display("No half-rate pulse seen on any lane");
            errs[2]++;
        end
        for (int t = 0; t < 4; t++)
            report_test(t);

        // Resync at a random point in the third window
        gap = $urandom_range(200, 1);
        repeat (gap) @(negedge clk);
        resync       = 1'b1;
        after_resync = 1'b1;
        @(negedge clk);
        resync = 1'b0;
        while (valid_seen < 3)
            @(negedge clk);
        repeat (2) @(negedge clk);
        report_test(4);

        for (int t = 0; t < NUM_TESTS; t++) begin
            total_checks += checks[t];
            total_errs   += errs[t];
        end
        if (UUT.u_chk.fails != 0) begin
            $display("Bound assertions failed %0d times", UUT.u_chk.fails);
            total_errs += UUT.u_chk.fails;
        end
        $display("Done: %0d tests, %0d checks, %0d errors", NUM_TESTS, total_checks, total_errs);
        if (total_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Run length limit
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
// Testbench clock source, free running with a period of 10
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // Half period
    end

endmodule

`default_nettype wire
